/* rtl/mc_net_pkg.sv */
/*
  Mesh packet format and endpoint sizing for the I/O node.
  IN_FIFO_DEPTH must be at least 2. Credits count stores only.
*/
`default_nettype none

package mc_net_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////
  localparam int unsigned X_CORD_W = 4;
  localparam int unsigned Y_CORD_W = 4;
  localparam int unsigned ADDR_W   = 16;              // Word address
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned OP_W     = 2;

  typedef enum logic [OP_W-1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1
  } mc_op_e;

  typedef struct packed {
    mc_op_e              op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [X_CORD_W-1:0] src_x;
    logic [Y_CORD_W-1:0] src_y;
    logic [X_CORD_W-1:0] dst_x;
    logic [Y_CORD_W-1:0] dst_y;
  } mc_packet_s;

  localparam int unsigned MC_PACKET_W = 66;           // Matches mc_packet_s

  ////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////
  localparam int unsigned MAX_OUT_CREDITS = 4;        // Outstanding stores
  localparam int unsigned CREDIT_W        = 3;

  localparam int unsigned IN_FIFO_DEPTH   = 2;
  localparam int unsigned IN_FIFO_PTR_W   = $clog2(IN_FIFO_DEPTH);
  localparam int unsigned IN_FIFO_CNT_W   = $clog2(IN_FIFO_DEPTH + 1);

endpackage

`default_nettype wire

/* rtl/mc_io_map_pkg.sv */
/*
  Address map of the I/O node. Addresses are word addresses,
  only exact matches decode.
*/
`default_nettype none

package mc_io_map_pkg;

  // Own mesh position, used as source of all loader stores
  localparam int unsigned IO_X_CORD = 0;
  localparam int unsigned IO_Y_CORD = 0;

  ////////////////////////////////////////////////////////////
  // Register addresses
  ////////////////////////////////////////////////////////////
  typedef enum logic [15:0] {
    REG_FINISH     = 16'h0000,
    REG_PRINT_STAT = 16'h0004,
    REG_TARGET_X   = 16'h0008,
    REG_TARGET_Y   = 16'h000C
  } mc_io_reg_e;

  // Tile that the loader targets out of reset
  localparam int unsigned TARGET_X_RST = 1;
  localparam int unsigned TARGET_Y_RST = 1;

endpackage

`default_nettype wire

/* rtl/mc_io_ifs.sv */
/*
  Internal links of the I/O complex. ret_v follows each yumi by one cycle,
  out.ready already accounts for credits.
*/
`default_nettype none

// Request head from the endpoint FIFO and the monitor's answer
interface mc_req_if import mc_net_pkg::*; ();
  logic              v;
  mc_packet_s        pkt;
  logic              yumi;                            // Pops the FIFO head
  logic              ret_v;
  logic [DATA_W-1:0] ret_data;

  modport endp (output v, pkt, input yumi, ret_v, ret_data);
  modport mon  (input v, pkt, output yumi, ret_v, ret_data);
endinterface

// Store packets from the loader into the endpoint
interface mc_out_if import mc_net_pkg::*; ();
  logic                v;
  mc_packet_s          pkt;
  logic                ready;
  logic [CREDIT_W-1:0] credits;                       // Free for new words

  modport endp (input v, pkt, output ready, credits);
  modport ldr  (output v, pkt, input ready, credits);
endinterface

// Register access from the monitor, target tile out to the loader
interface mc_csr_if import mc_net_pkg::*; ();
  logic                we;
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W-1:0]   rdata;                         // Comb. from addr
  logic [X_CORD_W-1:0] target_x;
  logic [Y_CORD_W-1:0] target_y;

  modport mon (output we, addr, wdata, input rdata);
  modport csr (input we, addr, wdata, output rdata);
  modport tgt (output target_x, target_y);
  modport ldr (input target_x, target_y);
endinterface

`default_nettype wire

/* rtl/mc_endpoint.sv */
/*
  Mesh endpoint of the I/O node. One credit per store, returned by link_ret_v_i.
  out.credits excludes a packet still parked in the output register.
*/
`default_nettype none

module mc_endpoint import mc_net_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,

  mc_req_if.endp                 req,
  mc_out_if.endp                 out,

  input  wire logic              link_in_v_i,
  input  wire mc_packet_s        link_in_pkt_i,
  output logic                   link_in_ready_o,

  output logic                   link_out_v_o,
  output mc_packet_s             link_out_pkt_o,
  input  wire logic              link_out_ready_i,

  input  wire logic              link_ret_v_i,
  output logic                   link_ret_v_o,
  output logic [DATA_W-1:0]      link_ret_data_o
);

  ////////////////////////////////////////////////////////////
  // Input FIFO
  ////////////////////////////////////////////////////////////
  logic [MC_PACKET_W-1:0]   fifo_mem [IN_FIFO_DEPTH];
  logic [IN_FIFO_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [IN_FIFO_CNT_W-1:0] count_q;
  logic                     push, pop;

  assign link_in_ready_o = (count_q != IN_FIFO_CNT_W'(IN_FIFO_DEPTH));
  assign push            = link_in_v_i & link_in_ready_o;
  assign pop             = req.yumi;

  assign req.v   = (count_q != '0);
  assign req.pkt = mc_packet_s'(fifo_mem[rd_ptr_q]);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= link_in_pkt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == IN_FIFO_PTR_W'(IN_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == IN_FIFO_PTR_W'(IN_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Response was registered by the monitor already
  assign link_ret_v_o    = req.ret_v;
  assign link_ret_data_o = req.ret_data;

  ////////////////////////////////////////////////////////////
  // Output register and credits
  ////////////////////////////////////////////////////////////
  logic                out_v_q;
  mc_packet_s          out_pkt_q;
  logic [CREDIT_W-1:0] credit_q;
  logic [CREDIT_W-1:0] credits_avail;
  logic                out_load, out_sent;

  assign out_sent      = out_v_q & link_out_ready_i;
  assign credits_avail = credit_q - CREDIT_W'(out_v_q);
  assign out.credits   = credits_avail;
  assign out.ready     = (~out_v_q | link_out_ready_i) & (credits_avail > CREDIT_W'(1));
  assign out_load      = out.v & out.ready;

  always_ff @(posedge clk_i) begin
    if (out_load) begin
      out_pkt_q <= out.pkt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_v_q  <= 1'b0;
      credit_q <= CREDIT_W'(MAX_OUT_CREDITS);
    end else begin
      if (out_load) begin
        out_v_q <= 1'b1;
      end else if (link_out_ready_i) begin
        out_v_q <= 1'b0;
      end
      credit_q <= credit_q + CREDIT_W'(link_ret_v_i) - CREDIT_W'(out_sent);
    end
  end

  assign link_out_v_o   = out_v_q;
  assign link_out_pkt_o = out_pkt_q;

  // A return without a store in flight would overflow the counter
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= CREDIT_W'(MAX_OUT_CREDITS));

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (link_out_v_o && !link_out_ready_i) |=> (link_out_v_o && $stable(link_out_pkt_o)));

endmodule

`default_nettype wire

/* rtl/mc_io_monitor.sv */
/*
  Serves requests addressed to the I/O node, one per cycle.
  Byte masks are not supported, a store always writes the full word.
*/
`default_nettype none

module mc_io_monitor import mc_net_pkg::*, mc_io_map_pkg::*; (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,

  mc_req_if.mon             req,
  mc_csr_if.mon             csr,

  output logic              print_stat_v_o,
  output logic [DATA_W-1:0] print_stat_tag_o,
  output logic              finish_o
);

  mc_io_reg_e        reg_sel;
  logic              is_store;
  logic              ret_v_q;
  logic [DATA_W-1:0] ret_data_q;
  logic              print_v_q;
  logic [DATA_W-1:0] print_tag_q;
  logic              finish_q;

  assign req.yumi = req.v;                            // Never stalls
  assign reg_sel  = mc_io_reg_e'(req.pkt.addr);
  assign is_store = (req.pkt.op == OP_STORE);

  // Csr decodes the target registers itself
  assign csr.we    = req.yumi & is_store;
  assign csr.addr  = req.pkt.addr;
  assign csr.wdata = req.pkt.data;

  always_ff @(posedge clk_i) begin
    if (req.yumi) begin
      ret_data_q  <= is_store ? '0 : csr.rdata;
      print_tag_q <= req.pkt.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ret_v_q   <= 1'b0;
      print_v_q <= 1'b0;
      finish_q  <= 1'b0;
    end else begin
      ret_v_q   <= req.yumi;
      print_v_q <= req.yumi & is_store & (reg_sel == REG_PRINT_STAT);
      finish_q  <= req.yumi & is_store & (reg_sel == REG_FINISH);
    end
  end

  assign req.ret_v        = ret_v_q;
  assign req.ret_data     = ret_data_q;
  assign print_stat_v_o   = print_v_q;
  assign print_stat_tag_o = print_tag_q;
  assign finish_o         = finish_q;

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req.yumi |-> req.v);

endmodule

`default_nettype wire

/* rtl/mc_io_csr.sv */
/*
  Target tile registers of the SPMD loader. Writes keep the low coordinate bits,
  unmapped addresses read as zero.
*/
`default_nettype none

module mc_io_csr import mc_net_pkg::*, mc_io_map_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_n_i,

  mc_csr_if.csr     bus,
  mc_csr_if.tgt     tgt
);

  logic [X_CORD_W-1:0] target_x_q;
  logic [Y_CORD_W-1:0] target_y_q;
  mc_io_reg_e          reg_sel;

  assign reg_sel = mc_io_reg_e'(bus.addr);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      target_x_q <= X_CORD_W'(TARGET_X_RST);
      target_y_q <= Y_CORD_W'(TARGET_Y_RST);
    end else if (bus.we) begin
      if (reg_sel == REG_TARGET_X) begin
        target_x_q <= bus.wdata[X_CORD_W-1:0];
      end
      if (reg_sel == REG_TARGET_Y) begin
        target_y_q <= bus.wdata[Y_CORD_W-1:0];
      end
    end
  end

  always_comb begin
    case (reg_sel)
      REG_TARGET_X: bus.rdata = DATA_W'(target_x_q);  // Zero-extended
      REG_TARGET_Y: bus.rdata = DATA_W'(target_y_q);
      default:      bus.rdata = '0;
    endcase
  end

  assign tgt.target_x = target_x_q;
  assign tgt.target_y = target_y_q;

endmodule

`default_nettype wire

/* rtl/mc_spmd_loader.sv */
/*
  Streams host words as stores to a single target tile, no loads.
  After the last word it waits for all credits, then stays done until reset.
*/
`default_nettype none

module mc_spmd_loader import mc_net_pkg::*, mc_io_map_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,

  input  wire logic              host_v_i,
  input  wire logic [ADDR_W-1:0] host_addr_i,
  input  wire logic [DATA_W-1:0] host_data_i,
  input  wire logic              host_last_i,
  output logic                   host_ready_o,

  mc_out_if.ldr                  out,
  mc_csr_if.ldr                  tgt,

  output logic                   done_o
);

  typedef enum logic [1:0] {
    LD_STREAM,
    LD_DRAIN,
    LD_DONE
  } ld_state_e;

  ld_state_e state_q;
  logic      streaming;
  logic      host_acc;

  assign streaming    = (state_q == LD_STREAM);
  assign host_ready_o = streaming & out.ready;
  assign host_acc     = host_v_i & host_ready_o;

  ////////////////////////////////////////////////////////////
  // Store packet
  ////////////////////////////////////////////////////////////
  assign out.v         = streaming & host_v_i;
  assign out.pkt.op    = OP_STORE;
  assign out.pkt.addr  = host_addr_i;
  assign out.pkt.data  = host_data_i;
  assign out.pkt.src_x = X_CORD_W'(IO_X_CORD);
  assign out.pkt.src_y = Y_CORD_W'(IO_Y_CORD);
  assign out.pkt.dst_x = tgt.target_x;               // Sampled at acceptance
  assign out.pkt.dst_y = tgt.target_y;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= LD_STREAM;
    end else begin
      case (state_q)
        LD_STREAM: if (host_acc && host_last_i) state_q <= LD_DRAIN;
        // Credits only read full once the output register is empty too
        LD_DRAIN:  if (out.credits == CREDIT_W'(MAX_OUT_CREDITS)) state_q <= LD_DONE;
        default:   state_q <= LD_DONE;
      endcase
    end
  end

  assign done_o = (state_q == LD_DONE);

  a_no_word_when_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == LD_DONE) |-> !(host_v_i && host_ready_o));

endmodule

`default_nettype wire

/* rtl/mc_io_complex.sv */
/*
  I/O node of the mesh: endpoint, monitor, config registers and SPMD loader.
  Incoming requests are taken as addressed to this node.
*/
`default_nettype none

module mc_io_complex import mc_net_pkg::*, mc_io_map_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,

  input  wire logic                link_in_v_i,
  input  wire logic [OP_W-1:0]     link_in_op_i,
  input  wire logic [ADDR_W-1:0]   link_in_addr_i,
  input  wire logic [DATA_W-1:0]   link_in_data_i,
  input  wire logic [X_CORD_W-1:0] link_in_src_x_i,
  input  wire logic [Y_CORD_W-1:0] link_in_src_y_i,
  output logic                     link_in_ready_o,

  output logic                     link_out_v_o,
  output logic [OP_W-1:0]          link_out_op_o,
  output logic [ADDR_W-1:0]        link_out_addr_o,
  output logic [DATA_W-1:0]        link_out_data_o,
  output logic [X_CORD_W-1:0]      link_out_dst_x_o,
  output logic [Y_CORD_W-1:0]      link_out_dst_y_o,
  output logic [X_CORD_W-1:0]      link_out_src_x_o,
  output logic [Y_CORD_W-1:0]      link_out_src_y_o,
  input  wire logic                link_out_ready_i,

  input  wire logic                link_ret_v_i,
  output logic                     link_ret_v_o,
  output logic [DATA_W-1:0]        link_ret_data_o,

  input  wire logic                host_v_i,
  input  wire logic [ADDR_W-1:0]   host_addr_i,
  input  wire logic [DATA_W-1:0]   host_data_i,
  input  wire logic                host_last_i,
  output logic                     host_ready_o,

  output logic                     loader_done_o,
  output logic                     print_stat_v_o,
  output logic [DATA_W-1:0]        print_stat_tag_o,
  output logic                     finish_o
);

  mc_packet_s link_in_pkt;
  mc_packet_s link_out_pkt;

  assign link_in_pkt = '{
    op:    mc_op_e'(link_in_op_i),
    addr:  link_in_addr_i,
    data:  link_in_data_i,
    src_x: link_in_src_x_i,
    src_y: link_in_src_y_i,
    dst_x: X_CORD_W'(IO_X_CORD),
    dst_y: Y_CORD_W'(IO_Y_CORD)
  };

  assign link_out_op_o    = link_out_pkt.op;
  assign link_out_addr_o  = link_out_pkt.addr;
  assign link_out_data_o  = link_out_pkt.data;
  assign link_out_dst_x_o = link_out_pkt.dst_x;
  assign link_out_dst_y_o = link_out_pkt.dst_y;
  assign link_out_src_x_o = link_out_pkt.src_x;
  assign link_out_src_y_o = link_out_pkt.src_y;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////
  mc_req_if req_if ();
  mc_out_if out_if ();
  mc_csr_if csr_if ();

  mc_endpoint i_mc_endpoint (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req              (req_if.endp),
    .out              (out_if.endp),
    .link_in_v_i      (link_in_v_i),
    .link_in_pkt_i    (link_in_pkt),
    .link_in_ready_o  (link_in_ready_o),
    .link_out_v_o     (link_out_v_o),
    .link_out_pkt_o   (link_out_pkt),
    .link_out_ready_i (link_out_ready_i),
    .link_ret_v_i     (link_ret_v_i),
    .link_ret_v_o     (link_ret_v_o),
    .link_ret_data_o  (link_ret_data_o)
  );

  mc_io_monitor i_mc_io_monitor (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req              (req_if.mon),
    .csr              (csr_if.mon),
    .print_stat_v_o   (print_stat_v_o),
    .print_stat_tag_o (print_stat_tag_o),
    .finish_o         (finish_o)
  );

  mc_io_csr i_mc_io_csr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (csr_if.csr),
    .tgt     (csr_if.tgt)
  );

  mc_spmd_loader i_mc_spmd_loader (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .host_v_i     (host_v_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .host_last_i  (host_last_i),
    .host_ready_o (host_ready_o),
    .out          (out_if.ldr),
    .tgt          (csr_if.ldr),
    .done_o       (loader_done_o)
  );

endmodule

`default_nettype wire

/* tests/tb_mc_io_complex.sv */
/*
  Testbench of the I/O complex. Two loads, each after its own reset.
  Config writes and streaming never overlap, so the model updates targets on acceptance.
*/
`default_nettype none

module tb_mc_io_complex import mc_net_pkg::*, mc_io_map_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED        = 32'h6ff7_37fb;
  localparam int          NUM_WORDS   = 12;             // Host words per load
  localparam int          NUM_REQS    = 11;
  localparam int          TIMEOUT_CYC = 40 * (2 * NUM_WORDS + NUM_REQS) + 200;

  typedef struct packed {
    logic [31:0]       due;                             // Cycle of the response
    logic [DATA_W-1:0] rdata;
    logic              print;
    logic              fin;
    logic [DATA_W-1:0] tag;
  } resp_t;

  logic clk_i, rst_n_i;
  logic link_in_v_i, link_in_ready_o;
  logic [OP_W-1:0] link_in_op_i, link_out_op_o;
  logic [ADDR_W-1:0] link_in_addr_i, link_out_addr_o, host_addr_i;
  logic [DATA_W-1:0] link_in_data_i, link_out_data_o, link_ret_data_o, host_data_i;
  logic [X_CORD_W-1:0] link_in_src_x_i, link_out_dst_x_o, link_out_src_x_o;
  logic [Y_CORD_W-1:0] link_in_src_y_i, link_out_dst_y_o, link_out_src_y_o;
  logic link_out_v_o, link_out_ready_i, link_ret_v_i, link_ret_v_o;
  logic host_v_i, host_last_i, host_ready_o;
  logic loader_done_o, print_stat_v_o, finish_o;
  logic [DATA_W-1:0] print_stat_tag_o;

  mc_io_complex i_mc_io_complex (.*);

  ////////////////////////////////////////////////////////////
  // Clock, stimulus state, reference model
  ////////////////////////////////////////////////////////////
  always #4 clk_i = ~clk_i;

  logic [31:0] host_rng  = SEED;
  logic [31:0] stall_rng = SEED ^ 32'h5555_5555;
  logic [31:0] ret_rng   = SEED ^ 32'ha5a5_0f0f;
  int cyc = 0;
  int hold_until = 0;                                   // Returns withheld before this cycle
  int req_acc = 0;
  int ret_seen = 0;
  int ret_due_q [$];

  logic [MC_PACKET_W-1:0] out_pkt_flat, exp_head, last_acc_pkt, prev_pkt;
  logic [MC_PACKET_W-1:0] exp_q [$];
  logic [5:0]             ctrl_flat;
  resp_t                  resp_q [$];
  logic [X_CORD_W-1:0]    tgt_x_m;
  logic [Y_CORD_W-1:0]    tgt_y_m;
  int                     acc_cnt, sent_cnt, ret_cnt;
  logic                   acc_seen, last_seen, exp_done, stall_q;
  logic                   exp_ret_v, exp_print_v, exp_finish;
  logic [DATA_W-1:0]      exp_ret_data, exp_print_tag;

  assign out_pkt_flat = {link_out_op_o, link_out_addr_o, link_out_data_o, link_out_src_x_o,
                         link_out_src_y_o, link_out_dst_x_o, link_out_dst_y_o};
  assign ctrl_flat    = {link_out_v_o, link_ret_v_o, print_stat_v_o, finish_o,
                         loader_done_o, host_ready_o};

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (link_in_v_i && link_in_ready_o) req_acc <= req_acc + 1;
    if (link_ret_v_o) ret_seen <= ret_seen + 1;
  end

  always @(posedge clk_i) begin : stall_drive
    if (!rst_n_i) begin
      link_out_ready_i <= 1'b1;
    end else begin
      stall_rng = lcg_step(stall_rng);
      link_out_ready_i <= (stall_rng[31:30] != 2'b00); // About one stall in four
    end
  end

  // One credit back per sent store, 0 to 6 cycles later
  always @(posedge clk_i) begin : ret_drive
    if (!rst_n_i) begin
      ret_due_q.delete();
      link_ret_v_i <= 1'b0;
    end else begin
      if (link_out_v_o && link_out_ready_i) begin
        ret_rng = lcg_step(ret_rng);
        ret_due_q.push_back(cyc + 1 + int'(ret_rng[31:16] % 16'd7));
      end
      if (ret_due_q.size() != 0 && ret_due_q[0] <= cyc && cyc >= hold_until) begin
        link_ret_v_i <= 1'b1;
        void'(ret_due_q.pop_front());
      end else begin
        link_ret_v_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : ref_model
    logic [MC_PACKET_W-1:0] pkt;
    resp_t                  rsp;
    if (!rst_n_i) begin
      exp_q.delete();
      resp_q.delete();
      tgt_x_m = X_CORD_W'(TARGET_X_RST);
      tgt_y_m = Y_CORD_W'(TARGET_Y_RST);
      {acc_cnt, sent_cnt, ret_cnt} <= '0;
      {acc_seen, last_seen, exp_done, stall_q} <= '0;
      {exp_ret_v, exp_print_v, exp_finish} <= '0;
    end else begin
      if (host_v_i && host_ready_o) begin
        pkt = {OP_W'(OP_STORE), host_addr_i, host_data_i, X_CORD_W'(IO_X_CORD),
               Y_CORD_W'(IO_Y_CORD), tgt_x_m, tgt_y_m};
        exp_q.push_back(pkt);
        last_acc_pkt <= pkt;
      end
      if (link_out_v_o && link_out_ready_i && exp_q.size() != 0) void'(exp_q.pop_front());
      exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
      prev_pkt  <= out_pkt_flat;
      stall_q   <= link_out_v_o && !link_out_ready_i;
      acc_seen  <= host_v_i && host_ready_o;
      last_seen <= last_seen | (host_v_i && host_ready_o && host_last_i);
      acc_cnt   <= acc_cnt + int'(host_v_i && host_ready_o);
      sent_cnt  <= sent_cnt + int'(link_out_v_o && link_out_ready_i);
      ret_cnt   <= ret_cnt + int'(link_ret_v_i);
      exp_done  <= exp_done | (last_seen && acc_cnt == ret_cnt);

      // Monitor: answer two cycles after acceptance, one per cycle
      if (link_in_v_i && link_in_ready_o) begin
        rsp     = '0;
        rsp.due = 32'(cyc + 2);
        rsp.tag = link_in_data_i;
        if (link_in_op_i == OP_W'(OP_STORE)) begin
          rsp.print = (link_in_addr_i == REG_PRINT_STAT);
          rsp.fin   = (link_in_addr_i == REG_FINISH);
          if (link_in_addr_i == REG_TARGET_X) tgt_x_m = link_in_data_i[X_CORD_W-1:0];
          if (link_in_addr_i == REG_TARGET_Y) tgt_y_m = link_in_data_i[Y_CORD_W-1:0];
        end else if (link_in_addr_i == REG_TARGET_X) begin
          rsp.rdata = DATA_W'(tgt_x_m);
        end else if (link_in_addr_i == REG_TARGET_Y) begin
          rsp.rdata = DATA_W'(tgt_y_m);
        end
        resp_q.push_back(rsp);
      end
      if (resp_q.size() != 0 && resp_q[0].due <= 32'(cyc + 1)) begin
        rsp = resp_q.pop_front();
        exp_ret_v     <= 1'b1;
        exp_ret_data  <= rsp.rdata;
        exp_print_v   <= rsp.print;
        exp_print_tag <= rsp.tag;
        exp_finish    <= rsp.fin;
      end else begin
        {exp_ret_v, exp_print_v, exp_finish} <= '0;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYC);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string sig, input logic [67:0] exp_v,
                                 input logic [67:0] act_v);
    $display("CHECK FAILED at %0t: %s expected %0h, actual %0h", $time, sig, exp_v, act_v);
    $display("Simulation FAILED");
    $fatal(1, "mismatch on %s", sig);
  endtask

  a_reset_state: assert property (@(posedge clk_i) !rst_n_i |=> ctrl_flat == 6'b000001)
    else report_mismatch("reset control outputs", 6'b000001, $sampled(ctrl_flat));
  // At most one request per cycle and one retired per cycle, so the FIFO never fills
  a_in_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_in_ready_o)
    else report_mismatch("link_in_ready_o", 1'b1, $sampled(link_in_ready_o));
  a_word_appears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_seen |-> {link_out_v_o, out_pkt_flat} == {1'b1, last_acc_pkt})
    else report_mismatch("link_out after accept", {1'b1, $sampled(last_acc_pkt)},
                         {$sampled(link_out_v_o), $sampled(out_pkt_flat)});
  a_pkt_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (link_out_v_o && link_out_ready_i) |-> out_pkt_flat == exp_head)
    else report_mismatch("link_out_pkt", $sampled(exp_head), $sampled(out_pkt_flat));
  a_pkt_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_q |-> {link_out_v_o, out_pkt_flat} == {1'b1, prev_pkt})
    else report_mismatch("stalled link_out", {1'b1, $sampled(prev_pkt)},
                         {$sampled(link_out_v_o), $sampled(out_pkt_flat)});
  a_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sent_cnt - ret_cnt <= int'(MAX_OUT_CREDITS) - 1)
    else report_mismatch("outstanding stores", MAX_OUT_CREDITS - 1,
                         $sampled(sent_cnt - ret_cnt));
  a_ready_at_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (acc_cnt - ret_cnt >= int'(MAX_OUT_CREDITS) - 1) |-> !host_ready_o)
    else report_mismatch("host_ready_o", 1'b0, $sampled(host_ready_o));
  a_done_exact: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    loader_done_o == exp_done)
    else report_mismatch("loader_done_o", $sampled(exp_done), $sampled(loader_done_o));
  a_no_ready_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    loader_done_o |-> !host_ready_o)
    else report_mismatch("host_ready_o after done", 1'b0, $sampled(host_ready_o));
  a_ret_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_ret_v_o == exp_ret_v)
    else report_mismatch("link_ret_v_o", $sampled(exp_ret_v), $sampled(link_ret_v_o));
  a_ret_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_ret_v_o |-> link_ret_data_o == exp_ret_data)
    else report_mismatch("link_ret_data_o", $sampled(exp_ret_data), $sampled(link_ret_data_o));
  a_print_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    print_stat_v_o == exp_print_v)
    else report_mismatch("print_stat_v_o", $sampled(exp_print_v), $sampled(print_stat_v_o));
  a_print_tag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    print_stat_v_o |-> print_stat_tag_o == exp_print_tag)
    else report_mismatch("print_stat_tag_o", $sampled(exp_print_tag),
                         $sampled(print_stat_tag_o));
  a_finish: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    finish_o == exp_finish)
    else report_mismatch("finish_o", $sampled(exp_finish), $sampled(finish_o));

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////
  task automatic apply_reset();
    rst_n_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  task automatic send_req(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    link_in_v_i    <= 1'b1;
    link_in_op_i   <= op;
    link_in_addr_i <= addr;
    link_in_data_i <= data;
    do @(posedge clk_i); while (!link_in_ready_o);
    link_in_v_i <= 1'b0;
  endtask

  task automatic wait_responses();
    do @(posedge clk_i); while (ret_seen != req_acc);
  endtask

  task automatic do_req(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data);
    send_req(op, addr, data);
    wait_responses();
  endtask

  task automatic stream_load(input int hold);
    int i;
    hold_until <= cyc + hold;
    for (i = 0; i < NUM_WORDS; i++) begin
      host_rng = lcg_step(host_rng);
      host_addr_i <= host_rng[31:16];
      host_rng = lcg_step(host_rng);
      host_data_i <= host_rng;
      host_v_i    <= 1'b1;
      host_last_i <= (i == NUM_WORDS - 1);
      do @(posedge clk_i); while (!host_ready_o);
    end
    host_v_i    <= 1'b0;
    host_last_i <= 1'b0;
    while (!loader_done_o) @(posedge clk_i);
    host_v_i <= 1'b1;                                   // Must be refused once done
    repeat (4) @(posedge clk_i);
    host_v_i <= 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    {link_in_v_i, link_in_op_i, link_in_addr_i, link_in_data_i} = '0;
    link_in_src_x_i = 4'd2;
    link_in_src_y_i = 4'd3;
    link_out_ready_i = 1'b1;
    link_ret_v_i = 1'b0;
    {host_v_i, host_addr_i, host_data_i, host_last_i} = '0;

    // Default target, credits held back at first
    apply_reset();
    stream_load(24);

    apply_reset();
    do_req(OP_LOAD, REG_TARGET_X, '0);
    do_req(OP_LOAD, 16'h0040, '0);
    host_rng = lcg_step(host_rng);
    do_req(OP_STORE, REG_PRINT_STAT, host_rng);
    do_req(OP_STORE, REG_FINISH, 32'h1);
    do_req(OP_STORE, REG_TARGET_X, 32'habcd_0015);     // Upper bits dropped
    do_req(OP_STORE, REG_TARGET_Y, 32'h0000_00f3);
    do_req(OP_LOAD, REG_TARGET_X, '0);
    do_req(OP_LOAD, REG_TARGET_Y, '0);
    send_req(OP_STORE, REG_PRINT_STAT, 32'h1111_0001);
    send_req(OP_STORE, REG_PRINT_STAT, 32'h2222_0002);
    send_req(OP_LOAD, REG_TARGET_Y, '0);
    wait_responses();
    stream_load(0);

    @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* mc_io_complex.f */
rtl/mc_net_pkg.sv
rtl/mc_io_map_pkg.sv
rtl/mc_io_ifs.sv
rtl/mc_endpoint.sv
rtl/mc_io_monitor.sv
rtl/mc_io_csr.sv
rtl/mc_spmd_loader.sv
rtl/mc_io_complex.sv
tests/tb_mc_io_complex.sv

/* Bender.yml */
package:
  name: mc_io_complex

sources:
  # Packages and interfaces first
  - rtl/mc_net_pkg.sv
  - rtl/mc_io_map_pkg.sv
  - rtl/mc_io_ifs.sv
  # RTL
  - rtl/mc_endpoint.sv
  - rtl/mc_io_monitor.sv
  - rtl/mc_io_csr.sv
  - rtl/mc_spmd_loader.sv
  - rtl/mc_io_complex.sv
  - target: test
    files:
      - tests/tb_mc_io_complex.sv
